// ==== vlog.f ====
src/exec_pkg.sv
src/int_alu.sv
src/lsu_ctrl.sv
src/exec_commit.sv
src/exec_stage.sv
verif/exec_stage_chk.sv
verif/tb_exec_stage.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - files:
      - src/exec_pkg.sv
      - src/int_alu.sv
      - src/lsu_ctrl.sv
      - src/exec_commit.sv
      - src/exec_stage.sv
  - target: test
    files:
      - verif/exec_stage_chk.sv
      - verif/tb_exec_stage.sv

// ==== verif/tb_exec_stage.sv ====
// Testbench for the execute stage, random operands compared against a reference model
`timescale 1ns/1ps

module tb_exec_stage
    import exec_pkg::*;
();

    localparam int TIMEOUT = 20;

    logic      clk = 1'b0;
    logic      reset_n = 1'b0;
    logic      stall_i = 1'b0;
    logic      compressed_i = 1'b0;
    logic      exc_illegal_i = 1'b0;
    op_e       op_i = NOP;
    reg_addr_t rd_i = '0;
    word_t     pc_i = '0;
    word_t     rs1_data_i = '0;
    word_t     rs2_data_i = '0;
    word_t     operand2_i = '0;
    word_t     jump_imm_target_i = '0;
    word_t     mtvec_i = 32'h0000_0180;

    op_e       op_o;
    reg_addr_t rd_o;
    exc_code_e exception_code_o;
    byte_en_t  mem_write_enable_o;
    word_t     mem_address_o, mem_write_data_o, jump_target_o, ctx_switch_target_o, result_o;
    logic      mem_read_enable_o, jump_o, raise_exception_o, ctx_switch_o, write_enable_o;

    word_t     seed = 32'd65849;
    int        errors = 0;
    int        tests = 0;

    always #10 clk = ~clk;

    exec_stage i_exec_stage (.*);

    ////////////////////////////////////////
    // Stimulus and reference model
    ////////////////////////////////////////

    function automatic word_t next_rand();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    // Expected writeback value, reads pc and immediate from the driven inputs
    function automatic word_t model_result(op_e op, word_t a, word_t b);
        case (op)
            SUB:       return a - b;
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            SLL:       return a << b[4:0];
            SRL:       return a >> b[4:0];
            SRA:       return word_t'($signed(a) >>> b[4:0]);
            SLT:       return word_t'($signed(a) < $signed(b));
            SLTU:      return word_t'(a < b);
            LUI:       return b;
            AUIPC:     return jump_imm_target_i;
            JAL, JALR: return pc_i + (compressed_i ? 32'd2 : 32'd4);
            default:   return a + b;
        endcase
    endfunction

    task automatic check(input string name, input word_t expected, input word_t actual);
        assert (expected === actual) else begin
            $display("Error %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // Apply one operation at the rising edge, return where outputs are settled
    task automatic drive(input op_e op, input word_t a, input word_t b, input reg_addr_t rd,
                         input logic illegal);
        @(posedge clk);
        op_i              <= op;
        rs1_data_i        <= a;
        operand2_i        <= b;
        rs2_data_i        <= next_rand();
        rd_i              <= rd;
        compressed_i      <= a[7];
        exc_illegal_i     <= illegal;
        pc_i              <= next_rand() & ~32'd1;
        jump_imm_target_i <= next_rand() & ~32'd1;
        @(negedge clk);
    endtask

    // Wait for the issued operation in the writeback registers and compare
    task automatic retire(input string name, input word_t exp_result, input logic exp_we);
        int        cycles;
        op_e       op;
        reg_addr_t rd;
        op = op_i;
        rd = rd_i;
        cycles = 0;
        @(posedge clk);
        op_i          <= NOP;
        rd_i          <= '0;
        exc_illegal_i <= 1'b0;
        @(negedge clk);
        while (op_o !== op && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (op_o !== op) begin
            $display("Timeout: %s operation never reached the writeback registers", name);
            errors++;
        end else begin
            check(name, exp_result, result_o);
            check(name, word_t'(exp_we), word_t'(write_enable_o));
            check(name, word_t'(rd), word_t'(rd_o));
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        word_t      a;
        word_t      b;
        word_t      r;
        word_t      target;
        logic [6:0] conds;
        reg_addr_t  rd;
        op_e        op;
        exc_code_e  code;
        int         start;

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        start = errors;
        check("reset", '0, result_o);
        check("reset", '0, word_t'(write_enable_o));
        check("reset", '0, word_t'(rd_o));
        end_test("reset", start);

        // ADD through JALR, rd forced to zero now and then
        start = errors;
        for (int i = 0; i < 40; i++) begin
            r  = next_rand();
            op = op_e'(1 + r % 14);
            rd = (i % 5 == 0) ? '0 : reg_addr_t'(r >> 8);
            drive(op, next_rand(), next_rand(), rd, 1'b0);
            retire("alu", model_result(op, rs1_data_i, operand2_i), rd != '0);
        end
        end_test("alu", start);

        start = errors;
        drive(ADD, next_rand(), next_rand(), 5'd3, 1'b0);
        r = rs1_data_i + operand2_i;
        @(posedge clk);
        stall_i <= 1'b1;
        op_i    <= XOR;
        rd_i    <= 5'd9;
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check("stall", r, result_o);
            check("stall", 32'd3, word_t'(rd_o));
            check("stall", 32'd1, word_t'(write_enable_o));
        end
        @(posedge clk);
        stall_i <= 1'b0;
        retire("stall", rs1_data_i ^ operand2_i, 1'b1);
        end_test("stall", start);

        // Loads and stores, LB through SW
        start = errors;
        for (int i = 0; i < 24; i++) begin
            op = op_e'(LB + i % 8);
            drive(op, next_rand(), next_rand() & 32'hfff, 5'd7, 1'b0);
            r = rs1_data_i + operand2_i;
            check("memory", r & ~32'd3, mem_address_o);
            check("memory", word_t'(op inside {LB, LBU, LH, LHU, LW}), word_t'(mem_read_enable_o));
            check("memory", (op == SB) ? (32'd1 << r[1:0]) : (op == SH) ? (r[1] ? 32'hc : 32'h3)
                  : (op == SW) ? 32'hf : 32'h0, word_t'(mem_write_enable_o));
            check("memory", (op == SB) ? {4{rs2_data_i[7:0]}} : (op == SH)
                  ? {2{rs2_data_i[15:0]}} : rs2_data_i, mem_write_data_o);
            retire("memory", r, !(op inside {SB, SH, SW}));
        end
        end_test("memory", start);

        start = errors;
        for (int i = 0; i < 28; i++) begin
            op = (i % 7 == 6) ? JALR : op_e'(BEQ + i % 7);
            a  = next_rand();
            b  = (i % 3 == 0) ? a : next_rand();
            drive(op, a, b, 5'd12, 1'b0);
            // Bit order follows BEQ, BNE, BLT, BLTU, BGE, BGEU, then JALR
            conds = {1'b1, a >= b, $signed(a) >= $signed(b), a < b, $signed(a) < $signed(b),
                     a != b, a == b};
            target = (op == JALR) ? ((a + b) & ~32'd1) : jump_imm_target_i;
            check("branch", word_t'(conds[i % 7]), word_t'(jump_o));
            check("branch", word_t'(conds[i % 7]), word_t'(ctx_switch_o));
            check("branch", target, jump_target_o);
            check("branch", target, ctx_switch_target_o);
            retire("branch", model_result(op, a, b), op == JALR);
        end
        end_test("branch", start);

        // Illegal flag also rides on JAL and ECALL to test priority
        start = errors;
        for (int i = 0; i < 12; i++) begin
            op = (i % 4 == 1) ? EBREAK : (i % 4 == 2) ? JAL : ECALL;
            drive(op, next_rand(), next_rand(), 5'd15, i % 4 >= 2);
            code = exc_illegal_i ? ILLEGAL_INSTRUCTION
                 : (op == ECALL) ? ECALL_FROM_MMODE : BREAKPOINT;
            check("exception", 32'd1, word_t'(raise_exception_o));
            check("exception", word_t'(code), word_t'(exception_code_o));
            check("exception", 32'd1, word_t'(ctx_switch_o));
            check("exception", mtvec_i, ctx_switch_target_o);
            check("exception", 32'd0, word_t'(jump_o));
            retire("exception", model_result(op, rs1_data_i, operand2_i), 1'b0);
        end
        end_test("exception", start);

        $display("%0d tests, %0d check errors, %0d assertion failures", tests, errors,
                 i_exec_stage.i_exec_stage_chk.fail_count);
        if (errors == 0 && i_exec_stage.i_exec_stage_chk.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verif/exec_stage_chk.sv ====
// Bound checker for the execute stage writeback, trap target and address rules
`timescale 1ns/1ps

module exec_stage_chk
    import exec_pkg::*;
(
    input logic      clk,
    input logic      reset_n,
    input logic      stall_i,
    input op_e       op_i,
    input word_t     mtvec_i,
    input word_t     mem_address_o,
    input byte_en_t  mem_write_enable_o,
    input logic      raise_exception_o,
    input word_t     ctx_switch_target_o,
    input word_t     result_o,
    input logic      write_enable_o,
    input reg_addr_t rd_o
);

    int unsigned fail_count = 0;
    logic        no_write;

    // Stores, branches and traps leave the register file alone
    assign no_write = (mem_write_enable_o != '0) || raise_exception_o
                      || (op_i inside {BEQ, BNE, BLT, BLTU, BGE, BGEU});

    assert property (@(posedge clk) disable iff (!reset_n)
        (!stall_i && no_write) |=> !write_enable_o)
    else begin
        $error("register write enabled after a store, branch or exception");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        raise_exception_o |-> (ctx_switch_target_o == mtvec_i))
    else begin
        $error("trap target differs from mtvec");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!reset_n) mem_address_o[1:0] == 2'b00)
    else begin
        $error("memory address not word aligned");
        fail_count++;
    end

    // Writeback registers freeze for every stalled edge
    assert property (@(posedge clk) disable iff (!reset_n)
        stall_i |=> ($stable(result_o) && $stable(rd_o) && $stable(write_enable_o)))
    else begin
        $error("writeback registers changed while stalled");
        fail_count++;
    end

endmodule

bind exec_stage exec_stage_chk i_exec_stage_chk (.*);

// ==== src/exec_stage.sv ====
// Execute stage top level joining the integer ALU, load/store control and commit logic
`timescale 1ns/1ps

module exec_stage
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      stall_i,
    input  op_e       op_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  word_t     operand2_i,
    input  reg_addr_t rd_i,
    input  logic      compressed_i,
    input  word_t     jump_imm_target_i,
    input  word_t     mtvec_i,
    input  logic      exc_illegal_i,
    // Memory side
    output word_t     mem_address_o,
    output logic      mem_read_enable_o,
    output byte_en_t  mem_write_enable_o,
    output word_t     mem_write_data_o,
    // Control transfer
    output logic      jump_o,
    output word_t     jump_target_o,
    output logic      raise_exception_o,
    output exc_code_e exception_code_o,
    output logic      ctx_switch_o,
    output word_t     ctx_switch_target_o,
    // Writeback
    output word_t     result_o,
    output logic      write_enable_o,
    output reg_addr_t rd_o,
    output op_e       op_o
);

    word_t sum;
    word_t alu_result;
    logic  equal;
    logic  less;
    logic  less_unsigned;

    int_alu i_int_alu (
        .op_i              (op_i),
        .pc_i              (pc_i),
        .rs1_data_i        (rs1_data_i),
        .operand2_i        (operand2_i),
        .compressed_i      (compressed_i),
        .jump_imm_target_i (jump_imm_target_i),
        .sum_o             (sum),
        .equal_o           (equal),
        .less_o            (less),
        .less_unsigned_o   (less_unsigned),
        .alu_result_o      (alu_result)
    );

    lsu_ctrl i_lsu_ctrl (
        .op_i               (op_i),
        .sum_i              (sum),
        .rs2_data_i         (rs2_data_i),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    exec_commit i_exec_commit (
        .clk                 (clk),
        .reset_n             (reset_n),
        .stall_i             (stall_i),
        .op_i                (op_i),
        .rd_i                (rd_i),
        .exc_illegal_i       (exc_illegal_i),
        .sum_i               (sum),
        .alu_result_i        (alu_result),
        .jump_imm_target_i   (jump_imm_target_i),
        .mtvec_i             (mtvec_i),
        .equal_i             (equal),
        .less_i              (less),
        .less_unsigned_i     (less_unsigned),
        .mem_write_enable_i  (mem_write_enable_o),
        .jump_o              (jump_o),
        .jump_target_o       (jump_target_o),
        .raise_exception_o   (raise_exception_o),
        .exception_code_o    (exception_code_o),
        .ctx_switch_o        (ctx_switch_o),
        .ctx_switch_target_o (ctx_switch_target_o),
        .result_o            (result_o),
        .write_enable_o      (write_enable_o),
        .rd_o                (rd_o),
        .op_o                (op_o)
    );

endmodule

// ==== src/exec_commit.sv ====
// Branch and exception decision with the writeback registers of the execute stage
`timescale 1ns/1ps

module exec_commit
    import exec_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      stall_i,
    input  op_e       op_i,
    input  reg_addr_t rd_i,
    input  logic      exc_illegal_i,
    input  word_t     sum_i,
    input  word_t     alu_result_i,
    input  word_t     jump_imm_target_i,
    input  word_t     mtvec_i,
    input  logic      equal_i,
    input  logic      less_i,
    input  logic      less_unsigned_i,
    input  byte_en_t  mem_write_enable_i,
    output logic      jump_o,
    output word_t     jump_target_o,
    output logic      raise_exception_o,
    output exc_code_e exception_code_o,
    output logic      ctx_switch_o,
    output word_t     ctx_switch_target_o,
    output word_t     result_o,
    output logic      write_enable_o,
    output reg_addr_t rd_o,
    output op_e       op_o
);

    logic should_jump;
    logic is_branch;
    logic write_enable;

    ////////////////////////////////////////
    // Branch decision
    ////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            BEQ:       should_jump = equal_i;
            BNE:       should_jump = !equal_i;
            BLT:       should_jump = less_i;
            BLTU:      should_jump = less_unsigned_i;
            BGE:       should_jump = !less_i;
            BGEU:      should_jump = !less_unsigned_i;
            JAL, JALR: should_jump = 1'b1;
            default:   should_jump = 1'b0;
        endcase
    end

    // JALR target drops bit 0
    assign jump_target_o = (op_i == JALR) ? {sum_i[31:1], 1'b0} : jump_imm_target_i;
    assign jump_o        = should_jump && !raise_exception_o;

    ////////////////////////////////////////
    // Exceptions
    ////////////////////////////////////////

    assign raise_exception_o = exc_illegal_i || (op_i == ECALL) || (op_i == EBREAK);

    always_comb begin
        if (exc_illegal_i) begin
            exception_code_o = ILLEGAL_INSTRUCTION;
        end else if (op_i == ECALL) begin
            exception_code_o = ECALL_FROM_MMODE;
        end else if (op_i == EBREAK) begin
            exception_code_o = BREAKPOINT;
        end else begin
            exception_code_o = NO_EXC;
        end
    end

    assign ctx_switch_o        = raise_exception_o || jump_o;
    assign ctx_switch_target_o = raise_exception_o ? mtvec_i : jump_target_o;

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////

    assign is_branch    = op_i inside {BEQ, BNE, BLT, BLTU, BGE, BGEU};
    // Stores show up as an active strobe
    assign write_enable = (rd_i != '0) && !raise_exception_o && (mem_write_enable_i == '0)
                          && !is_branch && (op_i != NOP);

    // Registers freeze while the pipeline is stalled
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            result_o       <= '0;
            rd_o           <= '0;
            op_o           <= NOP;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
            result_o       <= alu_result_i;
            rd_o           <= rd_i;
            op_o           <= op_i;
        end
    end

endmodule

// ==== src/lsu_ctrl.sv ====
// Load/store control forming the word address, byte strobes and store data
`timescale 1ns/1ps

module lsu_ctrl
    import exec_pkg::*;
(
    input  op_e      op_i,
    input  word_t    sum_i,
    input  word_t    rs2_data_i,
    output word_t    mem_address_o,
    output logic     mem_read_enable_o,
    output byte_en_t mem_write_enable_o,
    output word_t    mem_write_data_o
);

    // Word aligned access, lanes select the bytes
    assign mem_address_o     = {sum_i[31:2], 2'b00};
    assign mem_read_enable_o = op_i inside {LB, LBU, LH, LHU, LW};

    ////////////////////////////////////////
    // Store strobes
    ////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            SB: begin
                unique case (sum_i[1:0])
                    2'b11:   mem_write_enable_o = 4'b1000;
                    2'b10:   mem_write_enable_o = 4'b0100;
                    2'b01:   mem_write_enable_o = 4'b0010;
                    default: mem_write_enable_o = 4'b0001;
                endcase
            end
            SH:      mem_write_enable_o = sum_i[1] ? 4'b1100 : 4'b0011;
            SW:      mem_write_enable_o = 4'b1111;
            default: mem_write_enable_o = 4'b0000;
        endcase
    end

    ////////////////////////////////////////
    // Store data
    ////////////////////////////////////////

    // Replicate so every lane carries the value
    always_comb begin
        unique case (op_i)
            SB:      mem_write_data_o = {4{rs2_data_i[7:0]}};
            SH:      mem_write_data_o = {2{rs2_data_i[15:0]}};
            default: mem_write_data_o = rs2_data_i;
        endcase
    end

endmodule

// ==== src/int_alu.sv ====
// Integer ALU producing the address sum, compare flags and the operation result
`timescale 1ns/1ps

module int_alu
    import exec_pkg::*;
(
    input  op_e   op_i,
    input  word_t pc_i,
    input  word_t rs1_data_i,
    input  word_t operand2_i,
    input  logic  compressed_i,
    input  word_t jump_imm_target_i,
    output word_t sum_o,
    output logic  equal_o,
    output logic  less_o,
    output logic  less_unsigned_o,
    output word_t alu_result_o
);

    shamt_t shamt;
    logic   is_link;
    word_t  link_step;
    word_t  sum2_a;
    word_t  sum2_b;
    word_t  sum2_result;
    word_t  sll_result;
    word_t  srl_result;
    word_t  sra_result;

    ////////////////////////////////////////
    // Adders and compares
    ////////////////////////////////////////

    // Main adder also feeds the memory address
    assign sum_o           = rs1_data_i + operand2_i;
    assign equal_o         = (rs1_data_i == operand2_i);
    assign less_o          = ($signed(rs1_data_i) < $signed(operand2_i));
    assign less_unsigned_o = (rs1_data_i < operand2_i);

    // Second adder for link address and subtraction
    assign is_link     = (op_i == JAL) || (op_i == JALR);
    assign link_step   = compressed_i ? LINK_STEP_COMPRESSED : LINK_STEP_FULL;
    assign sum2_a      = is_link ? pc_i : rs1_data_i;
    assign sum2_b      = is_link ? link_step : (~operand2_i + 32'd1);
    assign sum2_result = sum2_a + sum2_b;

    ////////////////////////////////////////
    // Shifter
    ////////////////////////////////////////

    assign shamt      = operand2_i[4:0];
    assign sll_result = rs1_data_i << shamt;
    assign srl_result = rs1_data_i >> shamt;
    assign sra_result = $signed(rs1_data_i) >>> shamt;

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////

    always_comb begin
        unique case (op_i)
            SUB, JAL, JALR: alu_result_o = sum2_result;
            AND:            alu_result_o = rs1_data_i & operand2_i;
            OR:             alu_result_o = rs1_data_i | operand2_i;
            XOR:            alu_result_o = rs1_data_i ^ operand2_i;
            SLL:            alu_result_o = sll_result;
            SRL:            alu_result_o = srl_result;
            SRA:            alu_result_o = sra_result;
            SLT:            alu_result_o = {31'b0, less_o};
            SLTU:           alu_result_o = {31'b0, less_unsigned_o};
            LUI:            alu_result_o = operand2_i;
            AUIPC:          alu_result_o = jump_imm_target_i;
            // Loads, stores and ADD take the plain sum
            default:        alu_result_o = sum_o;
        endcase
    end

endmodule

// ==== src/exec_pkg.sv ====
// Execute stage shared types, operation codes and exception causes

package exec_pkg;

    ////////////////////////////////////////
    // Word and field types
    ////////////////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [4:0]  shamt_t;

    // Link address increments for JAL/JALR
    localparam word_t LINK_STEP_FULL       = 32'd4;
    localparam word_t LINK_STEP_COMPRESSED = 32'd2;

    ////////////////////////////////////////
    // Decoded operations
    ////////////////////////////////////////

    typedef enum logic [4:0] {
        NOP,
        ADD, SUB,
        AND, OR, XOR,
        SLL, SRL, SRA,
        SLT, SLTU,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        ECALL, EBREAK
    } op_e;

    ////////////////////////////////////////
    // Exception causes
    ////////////////////////////////////////

    // Values follow the mcause encoding
    typedef enum logic [3:0] {
        NO_EXC              = 4'd0,
        ILLEGAL_INSTRUCTION = 4'd2,
        BREAKPOINT          = 4'd3,
        ECALL_FROM_MMODE    = 4'd11
    } exc_code_e;

endpackage
